// File: Makefile
TOP := tb_data_mem

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f list.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// File: dv/data_mem_sva.sv
module data_mem_sva (
  input logic clk,
  input logic reset,
  input logic mem_en,
  input logic load,
  input logic store,
  input logic rvalid,
  input logic fault
);
  timeunit 1ns;
  timeprecision 1ps;

  // assertion failures so far
  int assert_fails = 0;

  // never data and fault in the same response slot
  a_slot_excl: assert property (@(posedge clk) disable iff (reset)
    !(rvalid && fault))
    else begin
      assert_fails++;
      $error("rvalid and fault high in the same cycle");
    end

  // load not rejected answers in the next cycle
  a_load_resp: assert property (@(posedge clk) disable iff (reset)
    $past(mem_en && load) && !fault |-> rvalid)
    else begin
      assert_fails++;
      $error("load without fault gave no rvalid one cycle later");
    end

  // and nothing else raises rvalid
  a_no_spurious: assert property (@(posedge clk) disable iff (reset)
    rvalid |-> $past(mem_en && load && !store))
    else begin
      assert_fails++;
      $error("rvalid without a load request one cycle earlier");
    end

  // response flags cleared by reset
  a_reset_quiet: assert property (@(posedge clk)
    $past(reset) |-> (!rvalid && !fault))
    else begin
      assert_fails++;
      $error("rvalid or fault high right after reset");
    end

endmodule

bind data_mem_top data_mem_sva sva0 (
  .clk    (clk),
  .reset  (reset),
  .mem_en (mem_en),
  .load   (load),
  .store  (store),
  .rvalid (rvalid),
  .fault  (fault)
);

// File: dv/tb_data_mem.sv
module tb_data_mem;
  timeunit 1ns;
  timeprecision 1ps;
  import mem_pkg::*;

  // about 10 reset + 60 directed + 220 random cycles
  localparam int test_cycles = 300;
  localparam int max_cycles  = 2 * test_cycles;

  logic        clk;
  logic        reset;
  logic        mem_en;
  logic        load;
  logic        store;
  width_e      width;
  logic        sign_ex;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic        rvalid;
  logic        fault;

  // reference memory with one byte per address and a written flag
  logic [7:0]                 model_mem [byte_addr_limit];
  logic [byte_addr_limit-1:0] model_ok;

  // response expected for the request driven at the last edge
  logic        pend_load;
  logic        pend_fault;
  logic        pend_known;
  logic [31:0] pend_data;
  logic [31:0] pend_addr;
  // response expected in the current cycle
  logic        slot_load;
  logic        slot_fault;
  logic        slot_known;
  logic [31:0] slot_data;
  logic [31:0] slot_addr;

  logic [31:0] lfsr_state;
  int          errors;
  int          checks;
  int          cycle_count;

  data_mem_top dut0 (
    .clk     (clk),
    .reset   (reset),
    .mem_en  (mem_en),
    .load    (load),
    .store   (store),
    .width   (width),
    .sign_ex (sign_ex),
    .addr    (addr),
    .wdata   (wdata),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .fault   (fault)
  );

  always #20 clk = ~clk;

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = 32'd0;
    for (int i = 0; i < n; i++) begin
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // bytes covered by one access
  function automatic int item_bytes(input width_e w);
    case (w)
      w_byte:  return 1;
      w_half:  return 2;
      default: return 4;
    endcase
  endfunction

  // exactly one op with a known width, natural alignment and an address inside the memory
  function automatic logic legal_request(input logic ld, input logic st,
                                         input width_e w, input logic [31:0] a);
    logic ok;
    ok = (ld != st) && (a < 32'(byte_addr_limit));
    if (w == w_half && a[0]) begin
      ok = 1'b0;
    end else if (w == w_word && a[1:0] != 2'b00) begin
      ok = 1'b0;
    end else if (w != w_byte && w != w_half && w != w_word) begin
      ok = 1'b0;
    end
    return ok;
  endfunction

  // little endian so the lowest data byte goes to the lowest address
  function automatic void model_store(input width_e w, input logic [31:0] a,
                                      input logic [31:0] d);
    logic [11:0] idx;
    for (int i = 0; i < 4; i++) begin
      if (i < item_bytes(w)) begin
        idx = a[11:0] + 12'(i);
        model_mem[idx] = d[i*8 +: 8];
        model_ok[idx]  = 1'b1;
      end
    end
  endfunction

  // gather the item, then zero or sign fill above it
  function automatic void model_load(input width_e w, input logic [31:0] a, input logic sx,
                                     output logic [31:0] v, output logic known);
    logic [11:0] idx;
    v     = 32'd0;
    known = 1'b1;
    for (int i = 0; i < 4; i++) begin
      if (i < item_bytes(w)) begin
        idx = a[11:0] + 12'(i);
        v[i*8 +: 8] = model_mem[idx];
        if (!model_ok[idx]) begin
          known = 1'b0;
        end
      end
    end
    if (sx && w == w_byte && v[7]) begin
      v[31:8] = 24'hff_ffff;
    end else if (sx && w == w_half && v[15]) begin
      v[31:16] = 16'hffff;
    end
  endfunction

  // drive one request cycle and note the expected response
  task automatic request(input logic ld, input logic st, input width_e w,
                         input logic sx, input logic [31:0] a, input logic [31:0] d);
    logic        ok;
    logic [31:0] v;
    logic        known;
    @(posedge clk);
    mem_en  <= 1'b1;
    load    <= ld;
    store   <= st;
    width   <= w;
    sign_ex <= sx;
    addr    <= a;
    wdata   <= d;
    ok = legal_request(ld, st, w, a);
    v     = 32'd0;
    known = 1'b0;
    if (ok && st) begin
      model_store(w, a, d);
    end
    if (ok && ld) begin
      model_load(w, a, sx, v, known);
    end
    pend_load  = ok && ld;
    pend_fault = !ok;
    pend_known = known;
    pend_data  = v;
    pend_addr  = a;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      mem_en <= 1'b0;
      load   <= 1'b0;
      store  <= 1'b0;
      pend_load  = 1'b0;
      pend_fault = 1'b0;
      pend_known = 1'b0;
    end
  endtask

  task automatic check_slot();
    checks++;
    assert (rvalid == slot_load) else begin
      errors++;
      if (slot_load) begin
        $display("no rvalid pulse for the load at %h", slot_addr);
      end else begin
        $display("rvalid pulse without an accepted load, last addr %h", slot_addr);
      end
    end
    assert (fault == slot_fault) else begin
      errors++;
      if (slot_fault) begin
        $display("no fault pulse for the rejected request at %h", slot_addr);
      end else begin
        $display("fault pulse for a legal request at %h", slot_addr);
      end
    end
    if (slot_load && slot_known) begin
      assert (rdata == slot_data) else begin
        errors++;
        $display("error rdata addr %h expected %h got %h", slot_addr, slot_data, rdata);
      end
    end
    if (!slot_load && !rvalid) begin
      assert (rdata == 32'd0) else begin
        errors++;
        $display("error rdata expected %h got %h with no load", 32'd0, rdata);
      end
    end
  endtask

  // outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      check_slot();
    end
    slot_load  = pend_load;
    slot_fault = pend_fault;
    slot_known = pend_known;
    slot_data  = pend_data;
    slot_addr  = pend_addr;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("timeout after %0d cycles, tests did not finish", cycle_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic word_round_trip();
    logic [31:0] a [4];
    a = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0100, 32'h0000_0ffc};
    for (int i = 0; i < 4; i++) begin
      request(1'b0, 1'b1, w_word, 1'b0, a[i], random_bits(32));
    end
    for (int i = 0; i < 4; i++) begin
      request(1'b1, 1'b0, w_word, 1'b0, a[i], 32'd0);
    end
    idle(2);
  endtask

  // only the low item of the data may land
  task automatic lane_order();
    request(1'b0, 1'b1, w_byte, 1'b0, 32'h0000_0040, 32'hdead_be11);
    request(1'b0, 1'b1, w_byte, 1'b0, 32'h0000_0041, 32'hdead_be22);
    request(1'b0, 1'b1, w_byte, 1'b0, 32'h0000_0042, 32'hdead_be33);
    request(1'b0, 1'b1, w_byte, 1'b0, 32'h0000_0043, 32'hdead_be44);
    request(1'b1, 1'b0, w_word, 1'b0, 32'h0000_0040, 32'd0);
    // half at offset 2 touches only the upper lanes
    request(1'b0, 1'b1, w_half, 1'b0, 32'h0000_0042, 32'h5555_abcd);
    request(1'b1, 1'b0, w_word, 1'b0, 32'h0000_0040, 32'd0);
    idle(2);
  endtask

  task automatic load_extension();
    request(1'b0, 1'b1, w_word, 1'b0, 32'h0000_0080, 32'h80f1_7f85);
    for (int s = 0; s < 2; s++) begin
      for (int off = 0; off < 4; off++) begin
        request(1'b1, 1'b0, w_byte, s[0], 32'h0000_0080 + 32'(off), 32'd0);
      end
      request(1'b1, 1'b0, w_half, s[0], 32'h0000_0080, 32'd0);
      request(1'b1, 1'b0, w_half, s[0], 32'h0000_0082, 32'd0);
    end
    idle(2);
  endtask

  // bad request, then read the target word back
  task automatic reject_and_reload(input logic ld, input logic st, input width_e w,
                                   input logic [31:0] a);
    request(ld, st, w, 1'b0, a, 32'hffff_ffff);
    request(1'b1, 1'b0, w_word, 1'b0, 32'h0000_00c0, 32'd0);
  endtask

  task automatic rejected_requests();
    request(1'b0, 1'b1, w_word, 1'b0, 32'h0000_00c0, 32'h5a5a_a5a5);
    reject_and_reload(1'b0, 1'b1, w_half, 32'h0000_00c1);
    reject_and_reload(1'b0, 1'b1, w_word, 32'h0000_00c2);
    // aliases word 0x0c0 if the range check were missing
    reject_and_reload(1'b0, 1'b1, w_word, 32'h0000_10c0);
    reject_and_reload(1'b0, 1'b1, width_e'(2'd3), 32'h0000_00c0);
    reject_and_reload(1'b1, 1'b1, w_word, 32'h0000_00c0);
    reject_and_reload(1'b0, 1'b0, w_word, 32'h0000_00c0);
    reject_and_reload(1'b1, 1'b0, w_half, 32'h0000_00c3);
    idle(2);
  endtask

  task automatic back_to_back();
    logic [31:0] op;
    logic [31:0] wb;
    logic [31:0] sx;
    logic [31:0] off;
    logic [31:0] far;
    logic [31:0] d;
    logic [31:0] a;
    // fill the window so most loads are checkable
    for (int i = 0; i < 16; i++) begin
      request(1'b0, 1'b1, w_word, 1'b0, 32'h0000_0200 + 32'(i * 4), random_bits(32));
    end
    for (int n = 0; n < 200; n++) begin
      op  = random_bits(1);
      wb  = random_bits(2);
      sx  = random_bits(1);
      off = random_bits(6);
      far = random_bits(4);
      d   = random_bits(32);
      a   = 32'h0000_0200 + off;
      if (far == 32'd0) begin
        a = a + 32'h0000_1000;
      end
      request(op[0], !op[0], width_e'(wb[1:0]), sx[0], a, d);
    end
    idle(2);
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    mem_en      = 1'b0;
    load        = 1'b0;
    store       = 1'b0;
    width       = w_word;
    sign_ex     = 1'b0;
    addr        = 32'd0;
    wdata       = 32'd0;
    model_ok    = '0;
    pend_load   = 1'b0;
    pend_fault  = 1'b0;
    pend_known  = 1'b0;
    pend_data   = 32'd0;
    pend_addr   = 32'd0;
    lfsr_state  = 32'h86cc_dd52;
    errors      = 0;
    checks      = 0;
    cycle_count = 0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    idle(2);
    word_round_trip();
    lane_order();
    load_extension();
    rejected_requests();
    back_to_back();
    errors += dut0.sva0.assert_fails;
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: hdl/access_align.sv
module access_align (
  input  logic            clk,
  input  logic            reset,
  input  logic            mem_en,
  input  logic            load,
  input  logic            store,
  input  mem_pkg::width_e width,
  input  logic            sign_ex,
  input  logic [31:0]     addr,
  input  logic [31:0]     wdata,
  ram_if.access           bus,
  output logic            ld_valid,
  output logic [1:0]      ld_offset,
  output mem_pkg::width_e ld_width,
  output logic            ld_sign,
  output logic            fault
);
  import mem_pkg::*;

  logic                  bad_op;
  logic                  bad_width;
  logic                  misaligned;
  logic                  out_of_range;
  logic                  legal;
  logic [lane_count-1:0] lane_mask;
  mem_word_u             st_word;

  // exactly one of load and store
  assign bad_op = (load == store);

  // past the last byte of the ram
  assign out_of_range = (addr >= 32'(byte_addr_limit));

  // width decode, alignment and lane mask
  always_comb begin
    bad_width  = 1'b0;
    misaligned = 1'b0;
    lane_mask  = 4'b1111;
    case (width)
      w_byte: begin
        lane_mask = 4'b0001 << addr[1:0];
      end
      w_half: begin
        misaligned = addr[0];
        lane_mask  = 4'b0011 << {addr[1], 1'b0};
      end
      w_word: begin
        misaligned = |addr[1:0];
      end
      default: begin
        // reserved code
        bad_width = 1'b1;
      end
    endcase
  end

  assign legal = !bad_op && !bad_width && !misaligned && !out_of_range;

  // replicate the store item into every lane
  // be then picks the one that lands
  always_comb begin
    st_word.word = wdata;
    case (width)
      w_byte: begin
        for (int i = 0; i < lane_count; i++) begin
          st_word.bytes[i] = wdata[7:0];
        end
      end
      w_half: begin
        st_word.halves[0] = wdata[15:0];
        st_word.halves[1] = wdata[15:0];
      end
      default: begin
        st_word.word = wdata;
      end
    endcase
  end

  // request towards the ram, same cycle
  assign bus.en        = mem_en && legal;
  assign bus.we        = store;
  assign bus.word_addr = addr[word_addr_w+1:2];
  assign bus.be        = (legal && store) ? lane_mask : '0;
  assign bus.wdata     = st_word.word;

  // response slot flags
  always_ff @(posedge clk) begin
    if (reset) begin
      ld_valid <= 1'b0;
      fault    <= 1'b0;
    end else begin
      ld_valid <= mem_en && legal && load;
      fault    <= mem_en && !legal;
    end
  end

  // load details for the formatter, aligned with the ram read
  always_ff @(posedge clk) begin
    ld_offset <= addr[1:0];
    ld_width  <= width;
    ld_sign   <= sign_ex;
  end

endmodule

// File: hdl/data_mem_top.sv
module data_mem_top (
  input  logic            clk,
  input  logic            reset,
  input  logic            mem_en,
  input  logic            load,
  input  logic            store,
  input  mem_pkg::width_e width,
  input  logic            sign_ex,
  input  logic [31:0]     addr,
  input  logic [31:0]     wdata,
  output logic [31:0]     rdata,
  output logic            rvalid,
  output logic            fault
);
  import mem_pkg::*;

  // load details from the access stage, one cycle after the request
  logic       ld_valid;
  logic [1:0] ld_offset;
  width_e     ld_width;
  logic       ld_sign;

  // word request and read data between access stage and ram
  ram_if ram_bus ();

  // request check, lane steering, load detail register
  access_align u_align (
    .clk       (clk),
    .reset     (reset),
    .mem_en    (mem_en),
    .load      (load),
    .store     (store),
    .width     (width),
    .sign_ex   (sign_ex),
    .addr      (addr),
    .wdata     (wdata),
    .bus       (ram_bus.access),
    .ld_valid  (ld_valid),
    .ld_offset (ld_offset),
    .ld_width  (ld_width),
    .ld_sign   (ld_sign),
    .fault     (fault)
  );

  // byte-enabled word storage
  data_ram u_ram (
    .clk (clk),
    .bus (ram_bus.ram)
  );

  // byte/half select and extension on the read word
  load_format u_format (
    .raw       (ram_bus.rdata),
    .ld_valid  (ld_valid),
    .ld_offset (ld_offset),
    .ld_width  (ld_width),
    .ld_sign   (ld_sign),
    .rdata     (rdata),
    .rvalid    (rvalid)
  );

endmodule

// File: hdl/data_ram.sv
module data_ram (
  input logic clk,
  ram_if.ram  bus
);
  import mem_pkg::*;

  // word storage
  // no reset and no preload, contents are unknown until written
  logic [31:0] mem [depth_words];

  // registered read word
  logic [31:0] rd_q;

  // write port
  // one lane per be bit, untouched lanes keep their old byte
  always_ff @(posedge clk) begin
    if (bus.en && bus.we) begin
      for (int i = 0; i < lane_count; i++) begin
        if (bus.be[i]) begin
          mem[bus.word_addr][i*8 +: 8] <= bus.wdata[i*8 +: 8];
        end
      end
    end
  end

  // read port
  // old word appears after the edge, held while idle or writing
  always_ff @(posedge clk) begin
    if (bus.en && !bus.we) begin
      rd_q <= mem[bus.word_addr];
    end
  end

  assign bus.rdata = rd_q;

endmodule

// File: hdl/load_format.sv
module load_format (
  input  logic [31:0]     raw,
  input  logic            ld_valid,
  input  logic [1:0]      ld_offset,
  input  mem_pkg::width_e ld_width,
  input  logic            ld_sign,
  output logic [31:0]     rdata,
  output logic            rvalid
);
  import mem_pkg::*;

  mem_word_u   rd_word;
  logic [31:0] item;
  logic [31:0] item_mask;
  logic        item_msb;
  logic [31:0] fill;

  assign rd_word.word = raw;

  // pick the addressed item, right aligned
  // item_mask marks the bits that belong to it
  always_comb begin
    case (ld_width)
      w_byte: begin
        item      = {24'd0, rd_word.bytes[ld_offset]};
        item_mask = 32'h0000_00ff;
        item_msb  = rd_word.bytes[ld_offset][7];
      end
      w_half: begin
        // bit 1 of the offset selects the half
        item      = {16'd0, rd_word.halves[ld_offset[1]]};
        item_mask = 32'h0000_ffff;
        item_msb  = rd_word.halves[ld_offset[1]][15];
      end
      default: begin
        // whole word, nothing to extend
        item      = rd_word.word;
        item_mask = 32'hffff_ffff;
        item_msb  = rd_word.word[31];
      end
    endcase
  end

  // ones above the item only for a signed load with msb set
  assign fill = {32{ld_sign & item_msb}} & ~item_mask;

  // zero when no load completes, so old ram words stay hidden
  assign rdata  = ld_valid ? (item | fill) : 32'd0;
  assign rvalid = ld_valid;

endmodule

// File: hdl/mem_pkg.sv
package mem_pkg;

  // access width code as carried by the load/store instruction
  // code 3 is reserved and always rejected
  typedef enum logic [1:0] {
    w_byte = 2'd0,
    w_half = 2'd1,
    w_word = 2'd2
  } width_e;

  // byte lanes per memory word
  localparam int lane_count = 4;

  // ram depth in words
  localparam int depth_words = 1024;

  // word index width into the ram
  localparam int word_addr_w = $clog2(depth_words);

  // first byte address past the end of the ram
  localparam int byte_addr_limit = depth_words * lane_count;

  // one memory word, seen three ways
  // index 0 of each view is the lowest byte address (little endian)
  typedef union packed {
    // whole word
    logic [31:0] word;
    // two half-words, [0] at offset 0, [1] at offset 2
    logic [1:0][15:0] halves;
    // four bytes, [0] at offset 0 up to [3] at offset 3
    logic [lane_count-1:0][7:0] bytes;
  } mem_word_u;

endpackage

// File: hdl/ram_if.sv
interface ram_if;
  import mem_pkg::*;

  // request side, driven by the access stage
  logic                   en;
  logic                   we;
  logic [word_addr_w-1:0] word_addr;
  logic [lane_count-1:0]  be;
  logic [31:0]            wdata;

  // read word, valid the cycle after a read edge
  logic [31:0]            rdata;

  // access stage view
  modport access (
    output en,
    output we,
    output word_addr,
    output be,
    output wdata,
    input  rdata
  );

  // ram view
  modport ram (
    input  en,
    input  we,
    input  word_addr,
    input  be,
    input  wdata,
    output rdata
  );

endinterface

// File: list.f
hdl/mem_pkg.sv
hdl/ram_if.sv
hdl/data_ram.sv
hdl/access_align.sv
hdl/load_format.sv
hdl/data_mem_top.sv
dv/data_mem_sva.sv
dv/tb_data_mem.sv
